//--- src.f
design/xcorrPkg.sv
design/sampleWindow.sv
design/lagAccumulator.sv
design/xcorrControl.sv
design/resultSerializer.sv
design/xcorrTop.sv
testbench/xcorrCredit_assert.sv
testbench/xcorrChecker.sv
testbench/tbXcorr.sv

//--- testbench/xcorrStim.txt
# s count hold ch0 ch1 ch2 ch3 : strobes, each waits for its frame | k hold ch0..ch3 : no wait
# m mode : 1 for slow credit return | e pair v0..v6 : expected sums for lags -3..+3
# Mid-scale input on every channel gives all-zero sums
e 0 0 0 0 0 0 0 0
e 1 0 0 0 0 0 0 0
e 2 0 0 0 0 0 0 0
e 3 0 0 0 0 0 0 0
e 4 0 0 0 0 0 0 0
e 5 0 0 0 0 0 0 0
s 1 2 2048 2048 2048 2048
# Fill the whole buffer with one constant, centered 10 -20 30 -5
s 23 2 2058 2028 2078 2043
# Three fresh samples with slow credits, the second strobe held high for 10 cycles
m 1
s 1 2 2048 2049 2050 2051
s 1 10 2048 2052 2053 2054
e 0 -2480 -2750 -2990 -3200 -3200 -3200 -3200
e 1 4050 4270 4520 4800 4800 4800 4800
e 2 -470 -610 -720 -800 -800 -800 -800
e 3 -8100 -8540 -9040 -9600 -9600 -9600 -9600
e 4 940 1220 1440 1600 1600 1600 1600
e 5 -1410 -1830 -2160 -2400 -2400 -2400 -2400
s 1 2 2048 2055 2056 2057
# New constant -7 11 13 -2, one strobe lands during readout and is skipped
s 20 2 2041 2059 2061 2046
k 2 2041 2059 2061 2046
s 1 2 2041 2059 2061 2046
e 0 -1232 -1232 -1232 -1232 -1232 -1232 -1232
e 1 -1456 -1456 -1456 -1456 -1456 -1456 -1456
e 2 224 224 224 224 224 224 224
e 3 2288 2288 2288 2288 2288 2288 2288
e 4 -352 -352 -352 -352 -352 -352 -352
e 5 -416 -416 -416 -416 -416 -416 -416
s 1 2 2041 2059 2061 2046

//--- testbench/tbXcorr.sv
////////////////////////////////////////////////////////////////////////////
// Cross-correlator testbench
// Replays the stimulus file, models a credit-returning consumer and
// hands expected frames to the checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tbXcorr
    import xcorrPkg::*;
();

    localparam int gapCycles    = 60;
    localparam int frameTimeout = 3000;

    logic      clk;
    logic      rst;
    logic      validIn;
    logic      creditReturn;
    sampleVec  samples;
    logic      resultValid;
    resultWord result;

    int        seed = 49768;
    int        fd;
    int        cycle = 0;
    int        lastDue = 0;
    int        dueQ[$];
    int        expectedFrames = 0;
    bit        slowCredits = 0;
    bit        skipNext = 0;
    resultWord pending[$];

    xcorrTop dut0 (
        .clk          (clk),
        .rst          (rst),
        .validIn      (validIn),
        .samples      (samples),
        .creditReturn (creditReturn),
        .resultValid  (resultValid),
        .result       (result)
    );

    xcorrChecker checker0 (
        .clk          (clk),
        .rst          (rst),
        .resultValid  (resultValid),
        .creditReturn (creditReturn),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Consumer model
    ////////////////////////////////////////////////////////////////////////////

    // Each received word schedules its credit, one return per cycle at most
    always @(negedge clk) begin : creditSchedule
        int delay;
        int due;
        if (!rst && resultValid) begin
            delay = slowCredits ? 10 + ($random(seed) & 15) : 1;
            due   = cycle + delay;
            if (due <= lastDue) begin
                due = lastDue + 1;
            end
            lastDue = due;
            dueQ.push_back(due);
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
            creditReturn <= 1'b1;
            dueQ.delete(0);
        end else begin
            creditReturn <= 1'b0;
        end
    end

    function automatic sampleVec makeSamples(input int a, input int b, input int c, input int d);
        sampleVec s;
        s.ch0 = sampleBits'(a);
        s.ch1 = sampleBits'(b);
        s.ch2 = sampleBits'(c);
        s.ch3 = sampleBits'(d);
        return s;
    endfunction

    task automatic applyStrobe(input int hold, input sampleVec s);
        @(posedge clk);
        samples <= s;
        validIn <= 1'b1;
        repeat (hold) @(posedge clk);
        validIn <= 1'b0;
        repeat (gapCycles) @(posedge clk);
    endtask

    // Frame done and every credit back, so the FSM is idle again
    task automatic waitFrames();
        int waited;
        waited = 0;
        while ((checker0.frameCount < expectedFrames || checker0.outstanding != 0)
               && waited < frameTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= frameTimeout) begin
            checker0.reportFailure("Timed out waiting for a result frame and its credits");
        end else if (checker0.frameCount != expectedFrames) begin
            checker0.reportFailure("More result frames arrived than strobes that should make one");
        end
    endtask

    task automatic flushPending();
        foreach (pending[i]) begin
            checker0.expectWord(pending[i]);
        end
        pending.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file commands
    ////////////////////////////////////////////////////////////////////////////

    task automatic runCommand(input logic [63:0] tag);
        logic [8*256-1:0] line;
        int               n;
        int               hold;
        int               a;
        int               b;
        int               c;
        int               d;
        int               p;
        int               v[lagCount];
        resultWord        w;
        if (tag == "#") begin
            void'($fgets(line, fd));
        end else if (tag == "m") begin
            void'($fscanf(fd, "%d", n));
            slowCredits = (n != 0);
        end else if (tag == "s" || tag == "k") begin
            if (tag == "s") begin
                void'($fscanf(fd, "%d", n));
            end else begin
                n = 1;
            end
            void'($fscanf(fd, "%d %d %d %d %d", hold, a, b, c, d));
            for (int i = 0; i < n; i++) begin
                if (i == n - 1) begin
                    flushPending();
                end
                applyStrobe(hold, makeSamples(a, b, c, d));
                if (skipNext) begin
                    skipNext = 0;
                end else begin
                    expectedFrames++;
                end
                if (tag == "s") begin
                    waitFrames();
                end
            end
            // The next strobe lands while this frame is still read out
            if (tag == "k") begin
                skipNext = 1;
            end
        end else if (tag == "e") begin
            void'($fscanf(fd, "%d %d %d %d %d %d %d %d", p, v[0], v[1], v[2], v[3], v[4],
                          v[5], v[6]));
            for (int l = 0; l < lagCount; l++) begin
                w.pairIdx = fieldBits'(p);
                w.lagIdx  = fieldBits'(l);
                w.last    = (p == numPairs - 1) && (l == lagCount - 1);
                w.value   = v[l];
                pending.push_back(w);
            end
        end else begin
            checker0.reportFailure("Unknown command tag in the stimulus file");
        end
    endtask

    initial begin : mainSequence
        logic [63:0] tag;
        int          code;
        bit          done;
        rst          = 1'b1;
        validIn      = 1'b0;
        creditReturn = 1'b0;
        samples      = '0;
        done         = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Nothing may stream before the first strobe
        repeat (10) @(posedge clk);
        checker0.recordTest("reset idle", checker0.frameCount + checker0.wordCount);

        fd = $fopen("testbench/xcorrStim.txt", "r");
        if (fd == 0) begin
            checker0.reportFailure("Could not open the stimulus file");
            done = 1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1;
            end else begin
                runCommand(tag);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        repeat (200) @(posedge clk);
        checker0.recordTest("frame count", int'(checker0.frameCount != expectedFrames));
        if (checker0.pendingCount() != 0) begin
            checker0.reportFailure("Some expected words were never read out");
        end
        $display("tests run %0d, failing %0d, errors %0d",
                 checker0.testCount, checker0.failCount, checker0.errorCount);
        if (checker0.errorCount == 0 && checker0.failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/xcorrChecker.sv
////////////////////////////////////////////////////////////////////////////
// Result stream checker
// Watches the output stream, checks word order, last flag, credit use and
// compares values against the expected words handed in by the testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module xcorrChecker
    import xcorrPkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      resultValid,
    input logic      creditReturn,
    input resultWord result
);

    resultWord expQ[$];
    int        wordCount   = 0;
    int        frameCount  = 0;
    int        outstanding = 0;
    int        errorCount  = 0;
    int        testCount   = 0;
    int        failCount   = 0;
    int        frameErrors = 0;
    bit        checking    = 0;

    task automatic expectWord(input resultWord w);
        expQ.push_back(w);
    endtask

    function automatic int pendingCount();
        return expQ.size();
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        errorCount++;
    endtask

    task automatic recordTest(input string name, input int errs);
        testCount++;
        if (errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            failCount++;
            $display("test %s: FAIL with %0d errors", name, errs);
        end
    endtask

    task automatic compareField(input string name, input int expV, input int gotV);
        if (expV != gotV) begin
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, expV, gotV);
            errorCount++;
            frameErrors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Word checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkWord();
        resultWord expWord;
        if (wordCount == 0) begin
            checking    = (expQ.size() > 0);
            frameErrors = 0;
        end
        // Order and last flag hold for every frame
        compareField("result.pairIdx", wordCount / lagCount, int'(result.pairIdx));
        compareField("result.lagIdx", wordCount % lagCount, int'(result.lagIdx));
        compareField("result.last", int'(wordCount == numWords - 1), int'(result.last));
        if (checking) begin
            expWord = expQ.pop_front();
            compareField("result.value", int'(expWord.value), int'(result.value));
        end
        wordCount++;
        if (wordCount == numWords) begin
            wordCount = 0;
            frameCount++;
            if (checking) begin
                recordTest($sformatf("frame %0d values", frameCount), frameErrors);
            end else if (frameErrors != 0) begin
                recordTest($sformatf("frame %0d order", frameCount), frameErrors);
            end
        end
    endtask

    // Sampled mid-cycle, where the DUT outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            wordCount   = 0;
            outstanding = 0;
        end else begin
            if (resultValid && !creditReturn) begin
                outstanding++;
            end else if (!resultValid && creditReturn) begin
                outstanding--;
            end
            if (outstanding > creditMax || outstanding < 0) begin
                reportFailure($sformatf("Outstanding word count left its range at %0t", $time));
            end
            if (resultValid) begin
                checkWord();
            end
        end
    end

endmodule

//--- testbench/xcorrCredit_assert.sv
////////////////////////////////////////////////////////////////////////////
// Credit and handshake assertions
// Bound into the correlator control block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module xcorrCreditAssert
    import xcorrPkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  resultValid,
    input logic                  creditReturn,
    input logic                  snapLoad,
    input readState              state,
    input logic [creditBits-1:0] credits
);

    // Words sent and not yet paid back, counted from the handshake alone
    int inFlight;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + int'(resultValid) - int'(creditReturn);
        end
    end

    // A word may only go out against a held credit
    validNeedsCredit: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> (inFlight < creditMax))
        else $error("resultValid high with no credit held");

    creditBound: assert property (@(posedge clk) disable iff (rst)
        credits <= creditBits'(creditMax))
        else $error("credit count above the consumer buffer size");

    // Snapshot only taken between frames
    snapInIdle: assert property (@(posedge clk) disable iff (rst)
        snapLoad |-> (state == idle))
        else $error("snapshot loaded while readout busy");

endmodule

bind xcorrControl xcorrCreditAssert assert0 (
    .clk          (clk),
    .rst          (rst),
    .resultValid  (resultValid),
    .creditReturn (creditReturn),
    .snapLoad     (snapLoad),
    .state        (state),
    .credits      (credits)
);

//--- design/xcorrTop.sv
////////////////////////////////////////////////////////////////////////////
// Cross-correlator top level
// Four-channel streaming correlator: sample window, one accumulator per
// channel pair, control and a credit-paced result stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module xcorrTop
    import xcorrPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      validIn,
    input  sampleVec  samples,
    input  logic      creditReturn,
    output logic      resultValid,
    output resultWord result
);

    logic                        shiftEn;
    logic                        accumEn;
    logic                        snapLoad;
    logic [indexBits-1:0]        wordIndex;
    windowTaps [numChannels-1:0] taps;
    lagVec [numPairs-1:0]        pairSums;

    xcorrControl control0 (
        .clk          (clk),
        .rst          (rst),
        .validIn      (validIn),
        .creditReturn (creditReturn),
        .shiftEn      (shiftEn),
        .accumEn      (accumEn),
        .snapLoad     (snapLoad),
        .wordIndex    (wordIndex),
        .resultValid  (resultValid)
    );

    sampleWindow window0 (
        .clk     (clk),
        .rst     (rst),
        .shiftEn (shiftEn),
        .samples (samples),
        .taps    (taps)
    );

    // One accumulator per channel pair, taps picked from the pair table
    for (genvar p = 0; p < numPairs; p++) begin : pairAcc
        lagAccumulator accum0 (
            .clk     (clk),
            .rst     (rst),
            .accumEn (accumEn),
            .fTaps   (taps[pairFirst[p]]),
            .gTaps   (taps[pairSecond[p]]),
            .sums    (pairSums[p])
        );
    end

    resultSerializer serializer0 (
        .clk       (clk),
        .rst       (rst),
        .snapLoad  (snapLoad),
        .wordIndex (wordIndex),
        .sums      (pairSums),
        .result    (result)
    );

endmodule

//--- design/resultSerializer.sv
////////////////////////////////////////////////////////////////////////////
// Result serializer
// Holds a snapshot of all pair sums and picks one output word per index,
// pair-major and lag-ascending
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module resultSerializer
    import xcorrPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    snapLoad,
    input  logic [indexBits-1:0]    wordIndex,
    input  lagVec [numPairs-1:0]    sums,
    output resultWord               result
);

    lagVec [numPairs-1:0]  snapshot;
    logic [fieldBits-1:0]  pairSel;
    logic [fieldBits-1:0]  lagSel;

    // Frozen copy, so readout is not disturbed by later accumulator updates
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snapshot <= '0;
        end else if (snapLoad) begin
            snapshot <= sums;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word decode
    ////////////////////////////////////////////////////////////////////////////

    // Seven lags per pair
    assign pairSel = fieldBits'(wordIndex / indexBits'(lagCount));
    assign lagSel  = fieldBits'(wordIndex % indexBits'(lagCount));

    assign result.pairIdx = pairSel;
    // Lag index 0 is lag -maxLag
    assign result.lagIdx  = lagSel;
    assign result.last    = (wordIndex == indexBits'(numWords - 1));
    assign result.value   = snapshot[pairSel][lagSel];

endmodule

//--- design/xcorrControl.sv
////////////////////////////////////////////////////////////////////////////
// Cross-correlator control
// Strobe edge detection, pipeline enables, snapshot handoff, readout FSM
// and the credit counter for the result stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module xcorrControl
    import xcorrPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 validIn,
    input  logic                 creditReturn,
    output logic                 shiftEn,
    output logic                 accumEn,
    output logic                 snapLoad,
    output logic [indexBits-1:0] wordIndex,
    output logic                 resultValid
);

    logic                  validQ;
    logic                  lastWord;
    readState              state;
    logic [creditBits-1:0] credits;

    ////////////////////////////////////////////////////////////////////////////
    // Strobe and pipeline enables
    ////////////////////////////////////////////////////////////////////////////

    // One pulse per rising edge of validIn, then one stage per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ   <= 1'b0;
            shiftEn  <= 1'b0;
            accumEn  <= 1'b0;
            snapLoad <= 1'b0;
        end else begin
            validQ   <= validIn;
            shiftEn  <= validIn & ~validQ;
            accumEn  <= shiftEn;
            // Snapshot dropped while a readout is still busy
            snapLoad <= accumEn & (state == idle);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readout FSM
    ////////////////////////////////////////////////////////////////////////////

    assign lastWord    = (wordIndex == indexBits'(numWords - 1));
    assign resultValid = (state == stream) && (credits != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            wordIndex <= '0;
        end else begin
            case (state)
                idle: begin
                    if (snapLoad) begin
                        state     <= stream;
                        wordIndex <= '0;
                    end
                end
                stream: begin
                    // Advance only on a word that was actually sent
                    if (resultValid) begin
                        if (lastWord) begin
                            state <= drain;
                        end else begin
                            wordIndex <= wordIndex + 1'b1;
                        end
                    end
                end
                drain: begin
                    // Wait until the consumer has taken the whole frame
                    if (credits == creditBits'(creditMax)) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Credit counter: a sent word spends one, a return gives one back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= creditBits'(creditMax);
        end else begin
            case ({resultValid, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- design/lagAccumulator.sv
////////////////////////////////////////////////////////////////////////////
// Lag accumulator
// Running sliding-window correlation of one channel pair at every lag,
// one entering product added and one leaving product removed per update
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lagAccumulator
    import xcorrPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      accumEn,
    input  windowTaps fTaps,
    input  windowTaps gTaps,
    output lagVec     sums
);

    // Each lag keeps its own running sum
    for (genvar l = 0; l < lagCount; l++) begin : lagSum

        logic signed [prodBits-1:0] addProd;
        logic signed [prodBits-1:0] subProd;
        accValue                    acc;

        // Product of the samples that just entered the window
        assign addProd = $signed(fTaps.addF) * $signed(gTaps.addG[l]);

        // Product of the samples that just fell out of it
        assign subProd = $signed(fTaps.subF) * $signed(gTaps.subG[l]);

        // Empty buffer entries are zero, so early sums only cover
        // the samples received so far
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                acc <= '0;
            end else if (accumEn) begin
                acc <= acc + addProd - subProd;
            end
        end

        assign sums[l] = acc;

    end

endmodule

//--- design/sampleWindow.sv
////////////////////////////////////////////////////////////////////////////
// Sample window
// Removes the mid-scale offset from each ADC sample and shifts it into a
// per-channel buffer, exposing the taps that enter and leave the window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sampleWindow
    import xcorrPkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         shiftEn,
    input  sampleVec                     samples,
    output windowTaps [numChannels-1:0]  taps
);

    logic [numChannels-1:0][sampleBits-1:0] raw;
    tapSample [numChannels-1:0]             centered;

    // Newest sample at entry 0, oldest at bufLen-1
    tapSample [bufLen-1:0] buffer [numChannels];

    assign raw[0] = samples.ch0;
    assign raw[1] = samples.ch1;
    assign raw[2] = samples.ch2;
    assign raw[3] = samples.ch3;

    for (genvar c = 0; c < numChannels; c++) begin : chan

        // Unsigned code to two's complement around mid-scale
        assign centered[c] = tapSample'($signed({1'b0, raw[c]}) - midScale);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                buffer[c] <= '0;
            end else if (shiftEn) begin
                buffer[c] <= {buffer[c][bufLen-2:0], centered[c]};
            end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Tap selection
        ////////////////////////////////////////////////////////////////////////////

        // f window spans entries maxLag to windowLen+maxLag-1
        assign taps[c].addF = buffer[c][maxLag];
        assign taps[c].subF = buffer[c][windowLen + maxLag];

        // g at lag index l lines up entry l with the f entry maxLag
        for (genvar l = 0; l < lagCount; l++) begin : lagTap
            assign taps[c].addG[l] = buffer[c][l];
            assign taps[c].subG[l] = buffer[c][windowLen + l];
        end

    end

endmodule

//--- design/xcorrPkg.sv
////////////////////////////////////////////////////////////////////////////
// Cross-correlator shared definitions
// Sizes, channel pair table, readout states and the packed bus types
// used between the window, accumulator, control and serializer blocks
////////////////////////////////////////////////////////////////////////////

package xcorrPkg;

    // Core sizes
    localparam int sampleBits  = 12;
    localparam int numChannels = 4;
    localparam int windowLen   = 16;
    localparam int maxLag      = 3;
    localparam int lagCount    = 2 * maxLag + 1;
    localparam int numPairs    = 6;
    localparam int xcorrBits   = 32;
    localparam int creditMax   = 4;

    // Derived sizes
    localparam int midScale    = 2 ** (sampleBits - 1);
    // One entry beyond the window span keeps the sample leaving at lag +maxLag
    localparam int bufLen      = windowLen + 2 * maxLag + 1;
    localparam int prodBits    = 2 * sampleBits;
    localparam int numWords    = numPairs * lagCount;
    localparam int indexBits   = $clog2(numWords);
    localparam int creditBits  = $clog2(creditMax + 1);
    localparam int fieldBits   = 3;

    // Channel pairs in output order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
    localparam int pairFirst  [numPairs] = '{0, 0, 0, 1, 1, 2};
    localparam int pairSecond [numPairs] = '{1, 2, 3, 2, 3, 3};

    typedef enum logic [1:0] {
        idle,
        stream,
        drain
    } readState;

    typedef logic signed [sampleBits-1:0] tapSample;
    typedef logic signed [xcorrBits-1:0]  accValue;

    // Raw ADC samples, unsigned, one per channel
    typedef struct packed {
        logic [sampleBits-1:0] ch0;
        logic [sampleBits-1:0] ch1;
        logic [sampleBits-1:0] ch2;
        logic [sampleBits-1:0] ch3;
    } sampleVec;

    // Taps of one channel buffer, f side and all g lags
    typedef struct packed {
        tapSample                addF;
        tapSample                subF;
        tapSample [lagCount-1:0] addG;
        tapSample [lagCount-1:0] subG;
    } windowTaps;

    typedef accValue [lagCount-1:0] lagVec;

    typedef struct packed {
        logic [fieldBits-1:0] pairIdx;
        logic [fieldBits-1:0] lagIdx;
        logic                 last;
        accValue              value;
    } resultWord;

endpackage
